//--- source/eeprom_params.svh
`ifndef EEPROM_PARAMS_SVH
`define EEPROM_PARAMS_SVH

// byte address of a 2 Kbyte part
`define EEPROM_ADDR_W 11

`define EEPROM_DATA_W 8

// device type code, top nibble of the control byte
`define EEPROM_CTRL_CODE 4'b1010

// CLK cycles per quarter of an scl bit
`define EEPROM_QUARTER 2

`endif

//--- source/eeprom_pkg.sv
`include "eeprom_params.svh"

package eeprom_pkg;

    typedef enum logic {
        CMD_WRITE = 1'b0,
        CMD_READ  = 1'b1
    } cmd_e;

    typedef struct packed {
        cmd_e                      cmd;
        logic [`EEPROM_ADDR_W-1:0] addr;
        logic [`EEPROM_DATA_W-1:0] wdata;
    } eeprom_req_t;

    typedef struct packed {
        logic [`EEPROM_DATA_W-1:0] rdata;  // zero for writes
        logic                      nack;
    } eeprom_rsp_t;

    typedef enum logic [1:0] {
        OP_START,
        OP_STOP,
        OP_BYTE_OUT,
        OP_BYTE_IN
    } bit_op_e;

    typedef struct packed {
        bit_op_e                   op;
        logic [`EEPROM_DATA_W-1:0] data;
    } bit_cmd_t;

    typedef struct packed {
        logic [`EEPROM_DATA_W-1:0] rdata;
        logic                      ack_missing;
    } bit_done_t;

    typedef enum logic [3:0] {
        C_IDLE,
        C_START,
        C_CTRL_WR,
        C_ADDR,
        C_DATA_WR,
        C_RESTART,
        C_CTRL_RD,
        C_DATA_RD,
        C_STOP,
        C_RESPOND
    } ctrl_state_e;

    typedef enum logic [2:0] {
        E_IDLE,
        E_START,
        E_STOP,
        E_BYTE_OUT,
        E_BYTE_IN
    } engine_state_e;

endpackage

//--- source/eeprom_bit_engine.sv
`include "eeprom_params.svh"

module eeprom_bit_engine (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  op_valid,
    output logic                  op_ready,
    input  eeprom_pkg::bit_cmd_t  op,
    output logic                  op_done,
    output eeprom_pkg::bit_done_t result,
    output logic                  scl,
    output logic                  sda_oe,
    output logic                  sda_out,
    input  logic                  sda_in
);
    import eeprom_pkg::*;

    localparam int cnt_w = (`EEPROM_QUARTER > 1) ? $clog2(`EEPROM_QUARTER) : 1;
    localparam logic [cnt_w-1:0] q_last = cnt_w'(`EEPROM_QUARTER - 1);
    localparam logic [3:0] ack_slot = 4'(`EEPROM_DATA_W);   // ninth bit
    localparam logic [3:0] last_data = ack_slot - 4'd1;

    engine_state_e             state;
    logic [cnt_w-1:0]          qcnt;      // CLK within a quarter
    logic [1:0]                quarter;
    logic [3:0]                bitcnt;
    logic [`EEPROM_DATA_W-1:0] shreg;
    logic [`EEPROM_DATA_W-1:0] inreg;
    logic                      ack_level;
    logic                      accept;
    logic                      last_q;
    logic                      sample;
    logic                      bit_end;
    logic                      op_end;

    assign op_ready = (state == E_IDLE);
    assign accept   = op_valid && op_ready;
    assign last_q   = (qcnt == q_last);

    // sda read at the end of the third quarter, scl high
    assign sample  = !op_ready && last_q && (quarter == 2'd2);
    assign bit_end = !op_ready && last_q && (quarter == 2'd3);
    assign op_end  = bit_end && ((state == E_START) || (state == E_STOP) ||
                                 (bitcnt == ack_slot));

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state   <= E_IDLE;
            qcnt    <= '0;
            quarter <= '0;
            bitcnt  <= '0;
            scl     <= 1'b1;
            sda_oe  <= 1'b0;
            sda_out <= 1'b1;
            op_done <= 1'b0;
        end
        else
        begin
            op_done <= 1'b0;
            if (accept)
            begin
                qcnt    <= '0;
                quarter <= '0;
                bitcnt  <= '0;
                scl     <= 1'b0;   // every op opens with scl low
                case (op.op)
                    OP_START:
                    begin
                        state   <= E_START;
                        sda_oe  <= 1'b1;
                        sda_out <= 1'b1;
                    end
                    OP_STOP:
                    begin
                        state   <= E_STOP;
                        sda_oe  <= 1'b1;
                        sda_out <= 1'b0;
                    end
                    OP_BYTE_OUT:
                    begin
                        state   <= E_BYTE_OUT;
                        sda_oe  <= 1'b1;
                        sda_out <= op.data[`EEPROM_DATA_W-1];   // msb first
                    end
                    default:
                    begin
                        state   <= E_BYTE_IN;
                        sda_oe  <= 1'b0;
                        sda_out <= 1'b1;
                    end
                endcase
            end
            else if (!op_ready)
            begin
                if (!last_q)
                    qcnt <= qcnt + 1'b1;
                else
                begin
                    qcnt    <= '0;
                    quarter <= quarter + 2'd1;
                    case (quarter)
                        2'd1:
                            scl <= 1'b1;
                        2'd2:
                        begin
                            if (state == E_START)
                                sda_out <= 1'b0;   // start condition
                            if (state == E_STOP)
                            begin
                                sda_oe  <= 1'b0;   // release, bus goes high
                                sda_out <= 1'b1;
                            end
                        end
                        2'd3:
                        begin
                            if (op_end)
                            begin
                                state   <= E_IDLE;
                                op_done <= 1'b1;
                            end
                            else
                            begin
                                bitcnt <= bitcnt + 4'd1;
                                scl    <= 1'b0;
                                if (state == E_BYTE_OUT)
                                begin
                                    // slave owns the ack slot
                                    sda_oe  <= (bitcnt != last_data);
                                    sda_out <= shreg[`EEPROM_DATA_W-2];
                                end
                                else
                                begin
                                    sda_oe  <= (bitcnt == last_data);   // master nack
                                    sda_out <= 1'b1;
                                end
                            end
                        end
                        default: ;
                    endcase
                end
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            shreg <= op.data;
            inreg <= '0;
        end
        else if (bit_end)
            shreg <= {shreg[`EEPROM_DATA_W-2:0], 1'b0};

        if (sample && (state == E_BYTE_IN) && (bitcnt != ack_slot))
            inreg <= {inreg[`EEPROM_DATA_W-2:0], sda_in};
        if (sample)
            ack_level <= sda_in;   // last one is the ninth bit

        if (op_end)
        begin
            result.rdata       <= (state == E_BYTE_IN) ? inreg : '0;
            result.ack_missing <= (state == E_BYTE_OUT) && ack_level;
        end
    end

endmodule

//--- source/eeprom_ctrl.sv
`include "eeprom_params.svh"

module eeprom_ctrl (
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    req_valid,
    output logic                    req_ready,
    input  eeprom_pkg::eeprom_req_t req,
    output logic                    rsp_valid,
    output eeprom_pkg::eeprom_rsp_t rsp,
    output logic                    op_valid,
    input  logic                    op_ready,
    output eeprom_pkg::bit_cmd_t    op,
    input  logic                    op_done,
    input  eeprom_pkg::bit_done_t   result
);
    import eeprom_pkg::*;

    ctrl_state_e                              state;
    ctrl_state_e                              step;      // state after the current op
    eeprom_req_t                              req_q;
    logic [`EEPROM_DATA_W-1:0]                rdata_q;
    logic                                     issued;    // op taken by the engine
    logic                                     nack;
    logic                                     is_read;
    logic [`EEPROM_ADDR_W-`EEPROM_DATA_W-1:0] block;

    assign req_ready = (state == C_IDLE);
    assign rsp_valid = (state == C_RESPOND);
    assign rsp.rdata = rdata_q;
    assign rsp.nack  = nack;

    assign is_read = (req_q.cmd == CMD_READ);
    // upper address bits ride in the control byte
    assign block   = req_q.addr[`EEPROM_ADDR_W-1:`EEPROM_DATA_W];

    assign op_valid = !issued && (state != C_IDLE) && (state != C_RESPOND);

    always_comb
    begin
        op.op   = OP_START;
        op.data = '0;
        case (state)
            C_CTRL_WR:
            begin
                op.op   = OP_BYTE_OUT;
                op.data = {`EEPROM_CTRL_CODE, block, 1'b0};
            end
            C_ADDR:
            begin
                op.op   = OP_BYTE_OUT;
                op.data = req_q.addr[`EEPROM_DATA_W-1:0];
            end
            C_DATA_WR:
            begin
                op.op   = OP_BYTE_OUT;
                op.data = req_q.wdata;
            end
            C_CTRL_RD:
            begin
                op.op   = OP_BYTE_OUT;
                op.data = {`EEPROM_CTRL_CODE, block, 1'b1};   // read bit set
            end
            C_DATA_RD:
                op.op = OP_BYTE_IN;
            C_STOP:
                op.op = OP_STOP;
            default: ;   // start and repeated start
        endcase
    end

    always_comb
    begin
        case (state)
            C_START:   step = C_CTRL_WR;
            C_CTRL_WR: step = C_ADDR;
            C_ADDR:    step = is_read ? C_RESTART : C_DATA_WR;
            C_RESTART: step = C_CTRL_RD;
            C_CTRL_RD: step = C_DATA_RD;
            C_STOP:    step = C_RESPOND;
            default:   step = C_STOP;   // data bytes close with stop
        endcase
        if (result.ack_missing)
            step = C_STOP;   // abort on missing ack
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state  <= C_IDLE;
            issued <= 1'b0;
            nack   <= 1'b0;
        end
        else
        begin
            case (state)
                C_IDLE:
                    if (req_valid && req_ready)
                    begin
                        state <= C_START;
                        nack  <= 1'b0;
                    end
                C_RESPOND:
                    state <= C_IDLE;
                default:
                    if (op_done)
                    begin
                        state  <= step;
                        issued <= 1'b0;
                        if (result.ack_missing)
                            nack <= 1'b1;   // sticky until next request
                    end
                    else if (op_valid && op_ready)
                        issued <= 1'b1;
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (req_valid && req_ready)
        begin
            req_q   <= req;
            rdata_q <= '0;
        end
        else if (op_done && (state == C_DATA_RD))
            rdata_q <= result.rdata;
    end

endmodule

//--- source/eeprom_top.sv
module eeprom_top (
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    req_valid,
    output logic                    req_ready,
    input  eeprom_pkg::eeprom_req_t req,
    output logic                    rsp_valid,
    output eeprom_pkg::eeprom_rsp_t rsp,
    output logic                    scl,
    output logic                    sda_oe,
    output logic                    sda_out,
    input  logic                    sda_in
);
    import eeprom_pkg::*;

    // sequencer to bit engine
    logic      op_valid;
    logic      op_ready;
    bit_cmd_t  op;
    logic      op_done;
    bit_done_t result;

    eeprom_ctrl ctrl_i (
        .CLK       (CLK),
        .RESET     (RESET),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .op_valid  (op_valid),
        .op_ready  (op_ready),
        .op        (op),
        .op_done   (op_done),
        .result    (result)
    );

    eeprom_bit_engine engine_i (
        .CLK      (CLK),
        .RESET    (RESET),
        .op_valid (op_valid),
        .op_ready (op_ready),
        .op       (op),
        .op_done  (op_done),
        .result   (result),
        .scl      (scl),
        .sda_oe   (sda_oe),
        .sda_out  (sda_out),
        .sda_in   (sda_in)
    );

endmodule

//--- bench/eeprom_model.sv
`include "eeprom_params.svh"

module eeprom_model (
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,          // resolved bus level
    input  logic nack_force,
    output logic sda_drive     // low pulls the bus down
);
    timeunit 1ns;
    timeprecision 100ps;

    typedef enum logic [2:0] {
        S_IDLE,
        S_RX,
        S_ACK,
        S_TX,
        S_TX_ACK
    } slave_state_e;

    logic [`EEPROM_DATA_W-1:0] mem [0:(1 << `EEPROM_ADDR_W)-1];
    slave_state_e              state;
    logic                      scl_q;
    logic                      sda_q;
    logic [3:0]                bitcnt;
    logic [`EEPROM_DATA_W-1:0] shreg;
    logic [1:0]                byte_idx;   // bytes since the last start
    logic                      read_mode;
    logic [2:0]                block;
    logic [`EEPROM_ADDR_W-1:0] ptr;

    // power-up content mixes all address bits
    initial
    begin
        logic [`EEPROM_ADDR_W-1:0] a;
        for (int i = 0; i < (1 << `EEPROM_ADDR_W); i++)
        begin
            a      = `EEPROM_ADDR_W'(i);
            mem[i] = a[`EEPROM_DATA_W-1:0] ^ a[`EEPROM_ADDR_W-1:`EEPROM_ADDR_W-`EEPROM_DATA_W];
        end
    end

    // bus only moves on rising CLK, so the falling edge sees settled levels
    always @(negedge CLK)
    begin
        if (RESET)
        begin
            state     <= S_IDLE;
            scl_q     <= 1'b1;
            sda_q     <= 1'b1;
            sda_drive <= 1'b1;
            read_mode <= 1'b0;
        end
        else
        begin
            scl_q <= scl;
            sda_q <= sda;
            if (scl && scl_q && sda_q && !sda)
            begin
                state     <= S_RX;   // start or repeated start
                bitcnt    <= '0;
                byte_idx  <= '0;
                sda_drive <= 1'b1;
            end
            else if (scl && scl_q && !sda_q && sda)
            begin
                state     <= S_IDLE;   // stop
                sda_drive <= 1'b1;
            end
            else if (scl && !scl_q)
            begin
                if (state == S_RX)
                begin
                    shreg  <= {shreg[`EEPROM_DATA_W-2:0], sda};
                    bitcnt <= bitcnt + 4'd1;
                end
                else if ((state == S_TX_ACK) && sda)
                    state <= S_IDLE;   // master nack ends the read
            end
            else if (!scl && scl_q)
            begin
                case (state)
                    S_RX:
                        if (bitcnt == 4'd8)
                        begin
                            if (nack_force ||
                                ((byte_idx == 2'd0) && (shreg[7:4] != `EEPROM_CTRL_CODE)))
                                state <= S_IDLE;   // ninth bit left released
                            else
                            begin
                                sda_drive <= 1'b0;
                                state     <= S_ACK;
                                byte_idx  <= byte_idx + 2'd1;
                                if (byte_idx == 2'd0)
                                begin
                                    block     <= shreg[3:1];
                                    read_mode <= shreg[0];
                                end
                                else if (byte_idx == 2'd1)
                                    ptr <= {block, shreg};
                                else
                                    mem[ptr] <= shreg;
                            end
                        end
                    S_ACK:
                    begin
                        bitcnt <= '0;
                        if (read_mode)
                        begin
                            state     <= S_TX;
                            shreg     <= mem[ptr];
                            sda_drive <= mem[ptr][`EEPROM_DATA_W-1];
                        end
                        else
                        begin
                            state     <= S_RX;
                            sda_drive <= 1'b1;
                        end
                    end
                    S_TX:
                        if (bitcnt == 4'd7)
                        begin
                            sda_drive <= 1'b1;   // master owns the ninth bit
                            state     <= S_TX_ACK;
                        end
                        else
                        begin
                            sda_drive <= shreg[`EEPROM_DATA_W-2];
                            shreg     <= {shreg[`EEPROM_DATA_W-2:0], 1'b0};
                            bitcnt    <= bitcnt + 4'd1;
                        end
                    default: ;
                endcase
            end
        end
    end

endmodule

//--- bench/tb_eeprom.sv
`include "eeprom_params.svh"

module tb_eeprom;
    timeunit 1ns;
    timeprecision 100ps;

    import eeprom_pkg::*;

    localparam int num_requests = 46;
    // a read takes at most 47 bit periods, doubled for margin
    localparam int watchdog_ns = num_requests * 47 * 4 * `EEPROM_QUARTER * 4 * 2;

    logic        CLK = 1'b0;
    logic        RESET = 1'b1;
    logic        req_valid = 1'b0;
    logic        req_ready;
    eeprom_req_t req = '0;
    logic        rsp_valid;
    eeprom_rsp_t rsp;
    logic        scl;
    logic        sda_oe;
    logic        sda_out;
    logic        sda_in;
    logic        slave_sda;
    logic        nack_force = 1'b0;

    logic [`EEPROM_DATA_W-1:0] shadow [0:(1 << `EEPROM_ADDR_W)-1];
    logic [`EEPROM_ADDR_W-1:0] last_wr = '0;
    eeprom_rsp_t               exp_q[$];
    string                     name_q[$];
    int                        rsp_count = 0;
    int                        sent_count = 0;
    integer                    seed = 11;

    assign sda_in = (sda_oe ? sda_out : 1'b1) & slave_sda;   // wired-and bus

    eeprom_top dut_i (
        .CLK       (CLK),
        .RESET     (RESET),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .scl       (scl),
        .sda_oe    (sda_oe),
        .sda_out   (sda_out),
        .sda_in    (sda_in)
    );

    eeprom_model slave_i (
        .CLK        (CLK),
        .RESET      (RESET),
        .scl        (scl),
        .sda        (sda_in),
        .nack_force (nack_force),
        .sda_drive  (slave_sda)
    );

    always #2 CLK = ~CLK;

    function automatic logic [`EEPROM_DATA_W-1:0] fill_value(logic [`EEPROM_ADDR_W-1:0] a);
        return a[`EEPROM_DATA_W-1:0] ^ a[`EEPROM_ADDR_W-1:`EEPROM_ADDR_W-`EEPROM_DATA_W];
    endfunction

    // shadow follows every write the slave acknowledges
    function automatic eeprom_rsp_t expected_rsp(eeprom_req_t r, logic forced);
        eeprom_rsp_t e;
        e.rdata = '0;
        e.nack  = forced;
        if (!forced)
        begin
            if (r.cmd == CMD_WRITE)
                shadow[r.addr] = r.wdata;
            else
                e.rdata = shadow[r.addr];
        end
        return e;
    endfunction

    function automatic eeprom_req_t random_request();
        eeprom_req_t r;
        logic [31:0] rnd;
        rnd     = $random(seed);
        r.cmd   = rnd[0] ? CMD_READ : CMD_WRITE;
        r.addr  = rnd[1 +: `EEPROM_ADDR_W];
        r.wdata = rnd[16 +: `EEPROM_DATA_W];
        if ((r.cmd == CMD_READ) && rnd[31])
            r.addr = last_wr;   // read back an earlier write
        else if (r.cmd == CMD_WRITE)
            last_wr = r.addr;
        return r;
    endfunction

    task automatic abort_run(string what);
        $display("[ERROR] %s", what);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_rsp(string test, eeprom_rsp_t exp, eeprom_rsp_t act);
        if (act !== exp)
        begin
            $display("[ERROR] %s: expected rdata=%h nack=%b, actual rdata=%h nack=%b",
                     test, exp.rdata, exp.nack, act.rdata, act.nack);
            $display("*** FAILED ***");
            $fatal(1, "response mismatch");
        end
    endtask

    task automatic check_bus_idle(string test);
        if ({scl, sda_oe, sda_in} !== 3'b101)
        begin
            $display("[ERROR] %s: expected scl/sda_oe/sda=101, actual %b%b%b",
                     test, scl, sda_oe, sda_in);
            $display("*** FAILED ***");
            $fatal(1, "bus not idle");
        end
    endtask

    task automatic compare_level(string test, logic exp, logic act);
        if (act !== exp)
        begin
            $display("[ERROR] %s: expected %b, actual %b", test, exp, act);
            $display("*** FAILED ***");
            $fatal(1, "handshake level mismatch");
        end
    endtask

    // called on a falling edge, returns one falling edge after acceptance
    task automatic issue_request(eeprom_req_t r, string test);
        req       = r;
        req_valid = 1'b1;
        while (!req_ready)
            @(negedge CLK);
        exp_q.push_back(expected_rsp(r, nack_force));
        name_q.push_back(test);
        sent_count++;
        @(negedge CLK);
        req_valid = 1'b0;
    endtask

    task automatic wait_responses();
        while (rsp_count < sent_count)
            @(negedge CLK);
    endtask

    task automatic run_request(eeprom_req_t r, string test);
        issue_request(r, test);
        wait_responses();
        check_bus_idle(test);
    endtask

    always @(negedge CLK)
    begin
        if (!RESET && rsp_valid)
        begin
            if (exp_q.size() == 0)
                abort_run("response arrived with no request pending");
            else
            begin
                check_rsp(name_q.pop_front(), exp_q.pop_front(), rsp);
                rsp_count++;
            end
        end
    end

    initial
    begin
        #(watchdog_ns);
        $display("[ERROR] no progress after %0d ns, the controller hung", watchdog_ns);
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        eeprom_req_t r;
        eeprom_req_t first;
        for (int i = 0; i < (1 << `EEPROM_ADDR_W); i++)
            shadow[i] = fill_value(`EEPROM_ADDR_W'(i));

        repeat (8) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;
        @(negedge CLK);
        check_bus_idle("after reset");
        compare_level("after reset rsp_valid", 1'b0, rsp_valid);
        compare_level("after reset req_ready", 1'b1, req_ready);

        r.cmd   = CMD_WRITE;
        r.addr  = 11'h5A3;
        r.wdata = 8'hC6;
        run_request(r, "write 0x5a3");
        r.cmd = CMD_READ;
        run_request(r, "read back 0x5a3");

        for (int i = 0; i < 40; i++)
            run_request(random_request(), $sformatf("random request %0d", i));

        r.cmd   = CMD_WRITE;
        r.addr  = 11'h2B7;
        r.wdata = 8'h3C;
        nack_force = 1'b1;
        run_request(r, "write with forced nack");
        nack_force = 1'b0;
        r.cmd = CMD_READ;
        run_request(r, "read after forced nack");

        // second request waits while the first one runs
        first.cmd   = CMD_WRITE;
        first.addr  = 11'h7FE;
        first.wdata = 8'h81;
        r.cmd       = CMD_READ;
        r.addr      = 11'h7FE;
        r.wdata     = '0;
        issue_request(first, "held pair write");
        req       = r;
        req_valid = 1'b1;
        while (!rsp_valid)
        begin
            if (req_ready)
                abort_run("second request was accepted while the first was still running");
            @(negedge CLK);
        end
        issue_request(r, "held pair read");
        wait_responses();
        check_bus_idle("after held pair");

        repeat (4) @(negedge CLK);
        if ((exp_q.size() == 0) && (rsp_count == num_requests))
        begin
            $display("*** PASSED ***");
            $finish;
        end
        else
        begin
            $display("[ERROR] %0d of %0d responses received", rsp_count, num_requests);
            $display("*** FAILED ***");
            $fatal(1, "missing responses");
        end
    end

endmodule

//--- files.f
+incdir+source
source/eeprom_pkg.sv
source/eeprom_bit_engine.sv
source/eeprom_ctrl.sv
source/eeprom_top.sv
bench/eeprom_model.sv
bench/tb_eeprom.sv

//--- run.sh
#!/bin/sh
# build and run with Verilator; sim.log decides the result
cd "$(dirname "$0")" || exit 1
rm -f sim.log
{ verilator --binary --timing --timescale 1ns/100ps --top-module tb_eeprom \
      -Mdir obj_dir -o sim_eeprom -f files.f &&
  ./obj_dir/sim_eeprom; } > sim.log 2>&1 || echo "build or simulation ended with an error" >> sim.log
cat sim.log
grep -q '^\*\*\* FAILED \*\*\*$' sim.log && exit 1
grep -q '^\*\*\* PASSED \*\*\*$' sim.log || exit 1
